// ==== hw/async_fifo.sv ====
`timescale 1ns/100ps

module async_fifo
  import fifo_geom_pkg::*;
  import gray_ptr_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  full,
  output logic                  empty,
  output logic                  afull,
  output logic                  aempty
);

  logic                  wr_push;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [PTR_WIDTH-1:0]  wr_gray; // Crosses into rd_clk.

  logic                  rd_pop;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [PTR_WIDTH-1:0]  rd_gray; // Crosses into wr_clk.

  wr_ptr_ctrl wr_ctrl0 (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .rd_gray  (rd_gray),
    .wr_push  (wr_push),
    .wr_addr  (wr_addr),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull)
  );

  rd_ptr_ctrl rd_ctrl0 (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_pop   (rd_pop),
    .rd_addr  (rd_addr),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Storage only trusts the qualified enables.
  dualport_ram_async ram0 (
    .wr_clk   (wr_clk),
    .wr_push  (wr_push),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_pop   (rd_pop),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

// ==== hw/dualport_ram_async.sv ====
`timescale 1ns/100ps

module dualport_ram_async
  import fifo_geom_pkg::*;
  import gray_ptr_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_push,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_pop,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // Write port.
  always_ff @(posedge wr_clk) begin
    if (wr_push) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, holds between pops.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_pop) begin
      rd_data <= mem[rd_addr]; // Word shows one cycle after pop.
    end
  end

endmodule

// ==== hw/fifo_geom_pkg.sv ====
package fifo_geom_pkg;

  // Width of one stored word.
  localparam int unsigned DATA_WIDTH = 8;

  // Number of words in the array, a power of two.
  localparam int unsigned FIFO_DEPTH = 16;

  // Write-side used count at or above which afull rises.
  localparam int unsigned FIFO_AFULL = 12;

  // Read-side used count at or below which aempty rises.
  localparam int unsigned FIFO_AEMPTY = 2;

endpackage

// ==== hw/gray_ptr_pkg.sv ====
package gray_ptr_pkg;

  import fifo_geom_pkg::*;

  localparam int unsigned ADDR_WIDTH = $clog2(FIFO_DEPTH); // RAM index bits.
  localparam int unsigned PTR_WIDTH  = ADDR_WIDTH + 1;      // Extra wrap bit.

  function automatic logic [PTR_WIDTH-1:0] bin_to_gray(
    input logic [PTR_WIDTH-1:0] bin
  );
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it.
  function automatic logic [PTR_WIDTH-1:0] gray_to_bin(
    input logic [PTR_WIDTH-1:0] gray
  );
    logic [PTR_WIDTH-1:0] bin;
    bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
    for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== hw/rd_ptr_ctrl.sv ====
`timescale 1ns/100ps

module rd_ptr_ctrl
  import fifo_geom_pkg::*;
  import gray_ptr_pkg::*;
(
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [PTR_WIDTH-1:0]  wr_gray,
  output logic                  rd_pop,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  output logic [PTR_WIDTH-1:0]  rd_gray,
  output logic                  empty,
  output logic                  aempty
);

  logic [PTR_WIDTH-1:0] rd_bin;
  logic [PTR_WIDTH-1:0] rd_bin_nxt;
  logic [PTR_WIDTH-1:0] wr_gray_meta;
  logic [PTR_WIDTH-1:0] wr_gray_sync;
  logic [PTR_WIDTH-1:0] wr_bin_sync;
  logic [PTR_WIDTH-1:0] used_nxt;
  logic                 empty_nxt;
  logic                 aempty_nxt;

  assign rd_pop  = rd_en && !empty; // Refuse reads while empty.
  assign rd_addr = rd_bin[ADDR_WIDTH-1:0];

  always_comb begin
    if (rd_pop) begin
      rd_bin_nxt = rd_bin + 1'b1;
    end else begin
      rd_bin_nxt = rd_bin;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= bin_to_gray(rd_bin_nxt);
    end
  end

  // Write pointer into the read domain.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
    end
  end

  assign wr_bin_sync = gray_to_bin(wr_gray_sync);

  // Used count never overstated, the write pointer seen here lags.
  assign used_nxt   = wr_bin_sync - rd_bin_nxt;
  assign empty_nxt  = (rd_bin_nxt == wr_bin_sync);
  assign aempty_nxt = (used_nxt <= PTR_WIDTH'(FIFO_AEMPTY));

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1; // Nothing stored out of reset.
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

endmodule

// ==== hw/wr_ptr_ctrl.sv ====
`timescale 1ns/100ps

module wr_ptr_ctrl
  import fifo_geom_pkg::*;
  import gray_ptr_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [PTR_WIDTH-1:0]  rd_gray,
  output logic                  wr_push,
  output logic [ADDR_WIDTH-1:0] wr_addr,
  output logic [PTR_WIDTH-1:0]  wr_gray,
  output logic                  full,
  output logic                  afull
);

  logic [PTR_WIDTH-1:0] wr_bin;
  logic [PTR_WIDTH-1:0] wr_bin_nxt;
  logic [PTR_WIDTH-1:0] rd_gray_meta;
  logic [PTR_WIDTH-1:0] rd_gray_sync;
  logic [PTR_WIDTH-1:0] rd_bin_sync;
  logic [PTR_WIDTH-1:0] rd_bin_wrap;
  logic [PTR_WIDTH-1:0] used_nxt;
  logic                 full_nxt;
  logic                 afull_nxt;

  assign wr_push = wr_en && !full; // Refuse writes while full.
  assign wr_addr = wr_bin[ADDR_WIDTH-1:0];

  always_comb begin
    if (wr_push) begin
      wr_bin_nxt = wr_bin + 1'b1;
    end else begin
      wr_bin_nxt = wr_bin;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= bin_to_gray(wr_bin_nxt); // Registered before it crosses.
    end
  end

  // Two-flop synchronizer for the read pointer.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  assign rd_bin_sync = gray_to_bin(rd_gray_sync);

  // Same index, opposite lap.
  assign rd_bin_wrap = {~rd_bin_sync[PTR_WIDTH-1], rd_bin_sync[PTR_WIDTH-2:0]};

  assign used_nxt  = wr_bin_nxt - rd_bin_sync;
  assign full_nxt  = (wr_bin_nxt == rd_bin_wrap);
  assign afull_nxt = (used_nxt >= PTR_WIDTH'(FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the async FIFO testbench with Verilator and run it.
# A $fatal in the testbench gives a nonzero exit status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_async_fifo \
  -f vlog.f \
  -o sim_async_fifo \
  && ./obj_dir/sim_async_fifo \
  || { echo "simulation did not complete successfully"; exit 1; }

// ==== testbench/tb_async_fifo.sv ====
`timescale 1ns/100ps

module tb_async_fifo
  import fifo_geom_pkg::*;
();

  localparam int unsigned WR_HALF   = 10; // 20 ns write clock.
  localparam int unsigned RD_HALF   = 13; // 26 ns read clock.
  localparam int          MAX_WAIT  = 200;
  localparam int          NUM_WORDS = 2000;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  full;
  logic                  empty;
  logic                  afull;
  logic                  aempty;

  logic [DATA_WIDTH-1:0] model_q [$]; // Words accepted and not yet popped.
  logic [DATA_WIDTH-1:0] rd_expect;   // Word rd_data must hold.
  int                    push_cnt;
  int                    pop_cnt;

  async_fifo dut0 (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .afull    (afull),
    .aempty   (aempty)
  );

  always #(WR_HALF) wr_clk = ~wr_clk;
  always #(RD_HALF) rd_clk = ~rd_clk;

  task automatic abort_run(input string msg);
    $display("ERROR: %s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
      abort_run("value mismatch");
    end
  endtask

  // Flags are stable from 2 ns after the edge until the next edge.
  task automatic write_cycle(input logic en, input logic [DATA_WIDTH-1:0] data);
    @(posedge wr_clk);
    #2;
    if (model_q.size() > int'(FIFO_DEPTH)) begin
      abort_run("more words accepted than the FIFO can hold");
    end
    if (model_q.size() == int'(FIFO_DEPTH)) begin
      check_equal("full", 32'd1, 32'(full));
    end
    wr_en   = en;
    wr_data = data;
    if (en && !full) begin
      model_q.push_back(data); // Stored on the next edge.
      push_cnt++;
    end
  endtask

  task automatic read_cycle(input logic en);
    @(posedge rd_clk);
    #2;
    check_equal("rd_data", 32'(rd_expect), 32'(rd_data));
    if (model_q.size() == 0) begin
      check_equal("empty", 32'd1, 32'(empty));
    end
    rd_en = en;
    if (en && !empty) begin
      if (model_q.size() == 0) begin
        abort_run("pop accepted with no word in the model");
      end
      rd_expect = model_q.pop_front(); // Shows after the next edge.
      pop_cnt++;
    end
  endtask

  task automatic run_writer(input int count);
    int          goal;
    int unsigned duty;
    int          n;
    goal = push_cnt + count;
    duty = 4;
    for (n = 0; n < 40000 && push_cnt < goal; n++) begin
      if (n % 64 == 0) begin
        duty = 1 + $urandom % 7; // Eighths of cycles with wr_en high.
      end
      write_cycle(($urandom % 8) < duty, DATA_WIDTH'($urandom));
    end
    if (push_cnt != goal) begin
      abort_run("writer could not push all words in time");
    end
    write_cycle(1'b0, '0);
  endtask

  task automatic run_reader(input int count);
    int          goal;
    int unsigned duty;
    int          n;
    goal = pop_cnt + count;
    duty = 4;
    for (n = 0; n < 60000 && pop_cnt < goal; n++) begin
      if (n % 64 == 0) begin
        duty = 1 + $urandom % 7;
      end
      read_cycle(($urandom % 8) < duty);
    end
    if (pop_cnt != goal) begin
      abort_run("reader could not pop all words in time");
    end
    read_cycle(1'b0);
  endtask

  task automatic fill_to(input int target);
    int n;
    n = 0;
    while (model_q.size() < target && n < MAX_WAIT) begin
      write_cycle(1'b1, DATA_WIDTH'($urandom));
      n++;
    end
    if (model_q.size() != target) begin
      abort_run("fill to the target level timed out");
    end
    write_cycle(1'b0, '0);
  endtask

  task automatic drain_to(input int target);
    int n;
    n = 0;
    while (model_q.size() > target && n < MAX_WAIT) begin
      read_cycle(1'b1);
      n++;
    end
    if (model_q.size() != target) begin
      abort_run("drain to the target level timed out");
    end
    read_cycle(1'b0);
  endtask

  // Flags converge once the idle pointers have crossed.
  task automatic settle_flags(input int level);
    logic exp_full;
    logic exp_afull;
    logic exp_empty;
    logic exp_aempty;
    int   n;
    exp_full   = (level == int'(FIFO_DEPTH));
    exp_afull  = (level >= int'(FIFO_AFULL));
    exp_empty  = (level == 0);
    exp_aempty = (level <= int'(FIFO_AEMPTY));
    for (n = 0; n < MAX_WAIT && full !== exp_full; n++) begin
      @(posedge wr_clk);
      #2;
    end
    if (full !== exp_full) abort_run("full never reached its settled value");
    for (n = 0; n < MAX_WAIT && afull !== exp_afull; n++) begin
      @(posedge wr_clk);
      #2;
    end
    if (afull !== exp_afull) abort_run("afull never reached its settled value");
    for (n = 0; n < MAX_WAIT && empty !== exp_empty; n++) begin
      @(posedge rd_clk);
      #2;
    end
    if (empty !== exp_empty) abort_run("empty never reached its settled value");
    for (n = 0; n < MAX_WAIT && aempty !== exp_aempty; n++) begin
      @(posedge rd_clk);
      #2;
    end
    if (aempty !== exp_aempty) abort_run("aempty never reached its settled value");
    check_equal("full", 32'(exp_full), 32'(full));
    check_equal("afull", 32'(exp_afull), 32'(afull));
    check_equal("empty", 32'(exp_empty), 32'(empty));
    check_equal("aempty", 32'(exp_aempty), 32'(aempty));
  endtask

  initial begin
    int start;
    int target;
    int i;
    void'($urandom(32));
    wr_clk    = 1'b0;
    rd_clk    = 1'b0;
    wr_rst_n  = 1'b0;
    rd_rst_n  = 1'b0;
    wr_en     = 1'b0;
    wr_data   = '0;
    rd_en     = 1'b0;
    rd_expect = '0;
    push_cnt  = 0;
    pop_cnt   = 0;
    repeat (2) @(posedge wr_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    // Reset state.
    check_equal("full", 32'd0, 32'(full));
    check_equal("afull", 32'd0, 32'(afull));
    check_equal("empty", 32'd1, 32'(empty));
    check_equal("aempty", 32'd1, 32'(aempty));
    check_equal("rd_data", 32'd0, 32'(rd_data));

    // Ordered transfer with both sides running.
    fork
      run_writer(NUM_WORDS);
      run_reader(NUM_WORDS);
    join
    settle_flags(0);

    // Writer keeps pushing into a stalled reader.
    start = push_cnt;
    repeat (40) write_cycle(1'b1, DATA_WIDTH'($urandom));
    write_cycle(1'b0, '0);
    check_equal("accepted pushes", 32'(FIFO_DEPTH), 32'(push_cnt - start));
    settle_flags(int'(FIFO_DEPTH));

    // Reader keeps popping past the last word.
    i = 0;
    while (model_q.size() > 0 && i < MAX_WAIT) begin
      read_cycle(1'b1);
      i++;
    end
    if (model_q.size() != 0) abort_run("reader could not drain the FIFO in time");
    repeat (8) read_cycle(1'b1); // Refused pops leave rd_data as it was.
    read_cycle(1'b0);
    settle_flags(0);

    // Almost flags at quiet random levels.
    for (i = 0; i < 24; i++) begin
      target = int'($urandom % (FIFO_DEPTH + 1));
      if (target > model_q.size()) begin
        fill_to(target);
      end else if (target < model_q.size()) begin
        drain_to(target);
      end
      settle_flags(target);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/fifo_geom_pkg.sv
hw/gray_ptr_pkg.sv
hw/dualport_ram_async.sv
hw/wr_ptr_ctrl.sv
hw/rd_ptr_ctrl.sv
hw/async_fifo.sv
testbench/tb_async_fifo.sv
